// ==== src/uart_pkg.sv ====
/* uart_pkg
   sizes, state codes and the received-character record shared by the
   uart blocks
*/
package uart_pkg;

   localparam int DATA_BITS       = 8;
   localparam int OVERSAMPLE      = 16;                          // sample ticks per bit
   localparam int CLKS_PER_SAMPLE = 4;
   localparam int CLKS_PER_BIT    = OVERSAMPLE * CLKS_PER_SAMPLE;
   localparam int FRAME_BITS      = DATA_BITS + 2;               // start, data, stop

   localparam int SAMPLE_CNT_W = $clog2(CLKS_PER_SAMPLE);
   localparam int OS_CNT_W     = $clog2(OVERSAMPLE);
   localparam int DATA_CNT_W   = $clog2(DATA_BITS);
   localparam int TX_CNT_W     = $clog2(FRAME_BITS + 1);

   localparam logic [SAMPLE_CNT_W-1:0] SAMPLE_LAST = SAMPLE_CNT_W'(CLKS_PER_SAMPLE - 1);
   localparam logic [OS_CNT_W-1:0]     OS_LAST     = OS_CNT_W'(OVERSAMPLE - 1);
   localparam logic [OS_CNT_W-1:0]     OS_HALF     = OS_CNT_W'(OVERSAMPLE / 2 - 1);
   localparam logic [DATA_CNT_W-1:0]   DATA_LAST   = DATA_CNT_W'(DATA_BITS - 1);
   localparam logic [TX_CNT_W-1:0]     TX_DONE     = TX_CNT_W'(FRAME_BITS);

   localparam logic [1:0] HS_IDLE    = 2'd0;   // four-phase req/ack states
   localparam logic [1:0] HS_ACTIVE  = 2'd1;
   localparam logic [1:0] HS_RELEASE = 2'd2;

   localparam logic [1:0] RX_HUNT  = 2'd0;     // receiver states
   localparam logic [1:0] RX_START = 2'd1;
   localparam logic [1:0] RX_DATA  = 2'd2;
   localparam logic [1:0] RX_STOP  = 2'd3;

   typedef struct packed {
      logic                 frame_err;   // stop bit sampled low
      logic [DATA_BITS-1:0] data;
   } rx_char_t;

endpackage

// ==== src/baud_tick_gen.sv ====
/* baud_tick_gen
   divides clk into the 16x oversampling tick for the receiver and the
   once-per-bit tick for the transmitter
*/
`timescale 1ns/10ps

module baud_tick_gen (
   input  logic clk,
   input  logic reset,
   output logic sample_tick,
   output logic bit_tick
);

   logic [uart_pkg::SAMPLE_CNT_W-1:0] clk_cnt;    // clocks within a sample period
   logic [uart_pkg::OS_CNT_W-1:0]     samp_cnt;   // sample ticks within a bit

   assign sample_tick = (clk_cnt == uart_pkg::SAMPLE_LAST);
   assign bit_tick    = sample_tick && (samp_cnt == uart_pkg::OS_LAST);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         clk_cnt <= '0;
      end
      else if (sample_tick)
      begin
         clk_cnt <= '0;
      end
      else
      begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

   // free running, frames align to whatever bit_tick comes next
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         samp_cnt <= '0;
      end
      else if (bit_tick)
      begin
         samp_cnt <= '0;
      end
      else if (sample_tick)
      begin
         samp_cnt <= samp_cnt + 1'b1;
      end
   end

endmodule

// ==== src/uart_rx.sv ====
/* uart_rx
   8N1 receiver. rx_in is synchronized and oversampled 16x, the start bit
   is confirmed at half a bit, data is taken mid-bit LSB first and the
   stop bit is checked before the character is handed on
*/
`timescale 1ns/10ps

module uart_rx (
   input  logic               clk,
   input  logic               reset,
   input  logic               sample_tick,
   input  logic               rx_in,
   output uart_pkg::rx_char_t rx_char,
   output logic               rx_strobe
);

   logic                            rx_meta;
   logic                            rx_sync;
   logic                            rx_prev;
   logic                            fall;      // high to low on the synced line
   logic                            mid_bit;   // sample point of a data or stop bit
   logic [1:0]                      state;
   logic [uart_pkg::OS_CNT_W-1:0]   os_cnt;
   logic [uart_pkg::DATA_CNT_W-1:0] bit_idx;
   logic [uart_pkg::DATA_BITS-1:0]  shift;

   assign fall    = rx_prev && !rx_sync;
   assign mid_bit = sample_tick && (os_cnt == uart_pkg::OS_LAST);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rx_meta <= 1'b1;   // line idles high
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end
      else
      begin
         rx_meta <= rx_in;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state     <= uart_pkg::RX_HUNT;
         os_cnt    <= '0;
         bit_idx   <= '0;
         rx_strobe <= 1'b0;
      end
      else
      begin
         rx_strobe <= 1'b0;
         case (state)
            uart_pkg::RX_HUNT:
               if (fall)
               begin
                  os_cnt <= '0;
                  state  <= uart_pkg::RX_START;
               end
            uart_pkg::RX_START:
               if (sample_tick)
               begin
                  if (os_cnt == uart_pkg::OS_HALF)
                  begin
                     os_cnt  <= '0;
                     bit_idx <= '0;
                     state   <= rx_sync ? uart_pkg::RX_HUNT : uart_pkg::RX_DATA;  // high is noise
                  end
                  else
                     os_cnt <= os_cnt + 1'b1;
               end
            uart_pkg::RX_DATA:
               if (sample_tick)
               begin
                  os_cnt <= os_cnt + 1'b1;   // wraps to zero at each mid-bit
                  if (mid_bit)
                  begin
                     bit_idx <= bit_idx + 1'b1;
                     if (bit_idx == uart_pkg::DATA_LAST)
                        state <= uart_pkg::RX_STOP;
                  end
               end
            default:
               if (sample_tick)
               begin
                  os_cnt <= os_cnt + 1'b1;
                  if (mid_bit)
                  begin
                     rx_strobe <= 1'b1;
                     state     <= uart_pkg::RX_HUNT;
                  end
               end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == uart_pkg::RX_DATA && mid_bit)
         shift <= {rx_sync, shift[uart_pkg::DATA_BITS-1:1]};   // lsb arrives first
      if (state == uart_pkg::RX_STOP && mid_bit)
      begin
         rx_char.data      <= shift;
         rx_char.frame_err <= !rx_sync;
      end
   end

endmodule

// ==== src/host_port.sv ====
/* host_port
   host side of the uart. two four-phase req/ack machines load the
   transmitter and unload the receive holding register, and the empty and
   overrun flags tell the host where each side stands
*/
`timescale 1ns/10ps

module host_port (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           ld_tx_req,
   output logic                           ld_tx_ack,
   input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
   output logic                           tx_empty,
   input  logic                           uld_rx_req,
   output logic                           uld_rx_ack,
   output logic [uart_pkg::DATA_BITS-1:0] rx_data,
   output logic                           rx_frame_err,
   output logic                           rx_empty,
   output logic                           rx_overrun,
   input  uart_pkg::rx_char_t             rx_char,
   input  logic                           rx_strobe,
   output logic [uart_pkg::DATA_BITS-1:0] tx_byte,
   output logic                           tx_start,
   input  logic                           tx_busy
);

   logic [1:0]         ld_state;
   logic [1:0]         uld_state;
   logic               tx_ready;
   logic               ld_go;     // load accepted at this edge
   logic               uld_go;    // unload accepted at this edge
   uart_pkg::rx_char_t rx_hold;

   // idle -> active on req (when ready), active -> release on req low, then idle
   function automatic logic [1:0] hs_next(input logic [1:0] state,
                                          input logic       req,
                                          input logic       ready);
      logic [1:0] nxt;
      nxt = state;
      case (state)
         uart_pkg::HS_IDLE:   if (req && ready) nxt = uart_pkg::HS_ACTIVE;
         uart_pkg::HS_ACTIVE: if (!req) nxt = uart_pkg::HS_RELEASE;
         default:             nxt = uart_pkg::HS_IDLE;
      endcase
      return nxt;
   endfunction

   assign tx_ready = !tx_busy && tx_empty;
   assign ld_go    = (ld_state == uart_pkg::HS_IDLE) && ld_tx_req && tx_ready;
   assign uld_go   = (uld_state == uart_pkg::HS_IDLE) && uld_rx_req;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ld_state  <= uart_pkg::HS_IDLE;
         ld_tx_ack <= 1'b0;
         tx_start  <= 1'b0;
         tx_empty  <= 1'b1;
      end
      else
      begin
         ld_state  <= hs_next(ld_state, ld_tx_req, tx_ready);
         ld_tx_ack <= (ld_state == uart_pkg::HS_ACTIVE) && ld_tx_req;
         tx_start  <= ld_go;
         tx_empty  <= !tx_busy;   // one clock late so it rises after the stop bit
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         uld_state    <= uart_pkg::HS_IDLE;
         uld_rx_ack   <= 1'b0;
         rx_data      <= '0;
         rx_frame_err <= 1'b0;
         rx_empty     <= 1'b1;
         rx_overrun   <= 1'b0;
      end
      else
      begin
         uld_state  <= hs_next(uld_state, uld_rx_req, 1'b1);
         uld_rx_ack <= (uld_state == uart_pkg::HS_ACTIVE) && uld_rx_req;
         if (uld_go && !rx_empty)
         begin
            rx_data      <= rx_hold.data;
            rx_frame_err <= rx_hold.frame_err;
         end
         if (rx_strobe)
            rx_empty <= 1'b0;   // new character beats a same-cycle unload
         else if (uld_go)
            rx_empty <= 1'b1;
         if (uld_go)
            rx_overrun <= 1'b0;
         else if (rx_strobe && !rx_empty)
            rx_overrun <= 1'b1;   // sticky, newest character kept
      end
   end

   always_ff @(posedge clk)
   begin
      if (ld_go)
         tx_byte <= tx_data;
      if (rx_strobe)
         rx_hold <= rx_char;
   end

endmodule

// ==== src/uart_tx.sv ====
/* uart_tx
   8N1 transmitter. a frame is latched on tx_start and shifted out one bit
   per bit_tick, start bit first and data LSB first, and tx_busy stays up
   until the stop bit has lasted a full bit time
*/
`timescale 1ns/10ps

module uart_tx (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           bit_tick,
   input  logic                           tx_start,
   input  logic [uart_pkg::DATA_BITS-1:0] tx_byte,
   output logic                           tx_out,
   output logic                           tx_busy
);

   logic [uart_pkg::FRAME_BITS-1:0] frame;     // stop, data, start from msb down
   logic [uart_pkg::TX_CNT_W-1:0]   bit_cnt;   // bits already on the line
   logic                            load;
   logic                            shift_en;
   logic                            frame_end;

   assign load      = !tx_busy && tx_start;
   assign frame_end = (bit_cnt == uart_pkg::TX_DONE);
   assign shift_en  = tx_busy && bit_tick && !frame_end;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         tx_busy <= 1'b0;
         tx_out  <= 1'b1;   // line idles high
         bit_cnt <= '0;
      end
      else if (load)
      begin
         tx_busy <= 1'b1;
         bit_cnt <= '0;
      end
      else if (shift_en)
      begin
         tx_out  <= frame[0];
         bit_cnt <= bit_cnt + 1'b1;
      end
      else if (tx_busy && bit_tick)
      begin
         tx_busy <= 1'b0;   // stop bit has been held one bit time
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
         frame <= {1'b1, tx_byte, 1'b0};
      else if (shift_en)
         frame <= {1'b1, frame[uart_pkg::FRAME_BITS-1:1]};
   end

endmodule

// ==== src/uart_top.sv ====
/* uart_top
   uart subsystem with a load/unload host port, one baud generator and an
   8N1 receiver and transmitter
*/
`timescale 1ns/10ps

module uart_top (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           ld_tx_req,
   output logic                           ld_tx_ack,
   input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
   output logic                           tx_out,
   output logic                           tx_empty,
   input  logic                           uld_rx_req,
   output logic                           uld_rx_ack,
   output logic [uart_pkg::DATA_BITS-1:0] rx_data,
   output logic                           rx_frame_err,
   output logic                           rx_empty,
   output logic                           rx_overrun,
   input  logic                           rx_in
);

   logic                           sample_tick;
   logic                           bit_tick;
   uart_pkg::rx_char_t             rx_char;
   logic                           rx_strobe;
   logic [uart_pkg::DATA_BITS-1:0] tx_byte;
   logic                           tx_start;
   logic                           tx_busy;

   baud_tick_gen baud0 (.clk, .reset, .sample_tick, .bit_tick);

   uart_rx rx0 (.clk, .reset, .sample_tick, .rx_in, .rx_char, .rx_strobe);

   host_port host0 (
      .clk, .reset,
      .ld_tx_req, .ld_tx_ack, .tx_data, .tx_empty,
      .uld_rx_req, .uld_rx_ack, .rx_data, .rx_frame_err, .rx_empty, .rx_overrun,
      .rx_char, .rx_strobe,
      .tx_byte, .tx_start, .tx_busy
   );

   uart_tx tx0 (.clk, .reset, .bit_tick, .tx_start, .tx_byte, .tx_out, .tx_busy);

endmodule

// ==== sim/tb_serial_model.svh ====
/* serial line model for the uart testbench
   send_frame drives one 8N1 character onto rx_in, read_frame waits for a
   start bit on tx_out and samples every bit at its middle
*/
`ifndef TB_SERIAL_MODEL_SVH
`define TB_SERIAL_MODEL_SVH

task automatic send_frame(input logic [7:0] data, input logic stop_level);
   logic [uart_pkg::FRAME_BITS-1:0] bits;
   bits = {stop_level, data, 1'b0};   // start bit leaves first
   for (int i = 0; i < uart_pkg::FRAME_BITS; i++)
   begin
      rx_in <= bits[i];
      repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
   end
   rx_in <= 1'b1;
   repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);   // one idle bit
endtask

task automatic read_frame(output logic [7:0] data);
   int waited;
   data   = '0;
   waited = 0;
   @(posedge clk);
   while (tx_out !== 1'b0 && waited < START_WAIT)
   begin
      @(posedge clk);
      waited++;
   end
   if (tx_out !== 1'b0)
   begin
      error_count++;
      $display("%0t: no start bit on tx_out within %0d cycles", $time, START_WAIT);
   end
   else
   begin
      repeat (uart_pkg::CLKS_PER_BIT / 2) @(posedge clk);   // middle of start bit
      check_bit("tx_out start bit", 1'b0, tx_out);
      for (int i = 0; i < uart_pkg::DATA_BITS; i++)
      begin
         repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
         data[i] = tx_out;   // lsb first
      end
      repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
      check_bit("tx_out stop bit", 1'b1, tx_out);
   end
endtask

`endif

// ==== sim/tb_uart.sv ====
/* tb_uart
   testbench for uart_top. loads and unloads bytes through the four-phase
   host port and models the serial line on tx_out and rx_in
*/
`timescale 1ns/10ps

module tb_uart;

   localparam int START_WAIT     = 4 * uart_pkg::CLKS_PER_BIT;    // bit alignment plus handshake
   localparam int HANDSHAKE_WAIT = 16 * uart_pkg::CLKS_PER_BIT;   // covers a busy transmitter

   logic       clk;
   logic       reset;
   logic       ld_tx_req;
   logic       ld_tx_ack;
   logic [7:0] tx_data;
   logic       tx_out;
   logic       tx_empty;
   logic       uld_rx_req;
   logic       uld_rx_ack;
   logic [7:0] rx_data;
   logic       rx_frame_err;
   logic       rx_empty;
   logic       rx_overrun;
   logic       rx_in;

   int    error_count = 0;
   int    test_count = 0;
   int    failed_count = 0;
   int    errors_at_start = 0;
   string test_name;

   uart_top dut0 (
      .clk, .reset,
      .ld_tx_req, .ld_tx_ack, .tx_data, .tx_out, .tx_empty,
      .uld_rx_req, .uld_rx_ack, .rx_data, .rx_frame_err, .rx_empty, .rx_overrun,
      .rx_in
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   // an ack only answers a request seen on the edge before
   ld_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      ld_tx_ack |-> $past(ld_tx_req))
   else
   begin
      error_count++;
      $display("%0t: ld_tx_ack high without a pending ld_tx_req", $time);
   end

   uld_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      uld_rx_ack |-> $past(uld_rx_req))
   else
   begin
      error_count++;
      $display("%0t: uld_rx_ack high without a pending uld_rx_req", $time);
   end

   ld_ack_needs_empty: assert property (@(posedge clk) disable iff (reset)
      $rose(ld_tx_ack) |-> $past(tx_empty))
   else
   begin
      error_count++;
      $display("%0t: ld_tx_ack rose while the transmitter was busy", $time);
   end

   idle_line_high: assert property (@(posedge clk) disable iff (reset)
      tx_empty |-> tx_out)
   else
   begin
      error_count++;
      $display("%0t: tx_out low while tx_empty is high", $time);
   end

   task automatic check_byte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
      assert (actual === expected)
      else
      begin
         error_count++;
         $display("ERROR %0t: %s expected 8'h%02h, got 8'h%02h", $time, name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      assert (actual === expected)
      else
      begin
         error_count++;
         $display("ERROR %0t: %s expected %b, got %b", $time, name, expected, actual);
      end
   endtask

   function automatic logic read_output(input string name);
      case (name)
         "ld_tx_ack":  return ld_tx_ack;
         "uld_rx_ack": return uld_rx_ack;
         "tx_empty":   return tx_empty;
         "rx_empty":   return rx_empty;
         default:      return 1'bx;
      endcase
   endfunction

   task automatic wait_level(input string name, input logic level, input int limit);
      int waited;
      waited = 0;
      @(posedge clk);
      while (read_output(name) !== level && waited < limit)
      begin
         @(posedge clk);
         waited++;
      end
      if (read_output(name) !== level)
      begin
         error_count++;
         $display("%0t: %s did not go to %b within %0d cycles", $time, name, level, limit);
      end
   endtask

   `include "tb_serial_model.svh"

   task automatic load_byte(input logic [7:0] data);
      tx_data   <= data;
      ld_tx_req <= 1'b1;
      wait_level("ld_tx_ack", 1'b1, HANDSHAKE_WAIT);
      ld_tx_req <= 1'b0;
      wait_level("ld_tx_ack", 1'b0, HANDSHAKE_WAIT);
   endtask

   task automatic unload_byte(output logic [7:0] data, output logic frame_err);
      uld_rx_req <= 1'b1;
      wait_level("uld_rx_ack", 1'b1, HANDSHAKE_WAIT);
      data      = rx_data;
      frame_err = rx_frame_err;
      uld_rx_req <= 1'b0;
      wait_level("uld_rx_ack", 1'b0, HANDSHAKE_WAIT);
   endtask

   task automatic open_test(input string name);
      test_name       = name;
      errors_at_start = error_count;
      test_count++;
   endtask

   task automatic close_test();
      if (error_count == errors_at_start)
         $display("test %0d %s: passed", test_count, test_name);
      else
      begin
         failed_count++;
         $display("test %0d %s: failed with %0d errors", test_count, test_name,
                  error_count - errors_at_start);
      end
   endtask

   initial
   begin
      logic [7:0]  byte_a;
      logic [7:0]  byte_b;
      logic [7:0]  got_a;
      logic [7:0]  got_b;
      logic        got_err;
      logic        seen_empty;
      int          waited;

      void'($urandom(28728));
      reset      = 1'b1;
      ld_tx_req  = 1'b0;
      tx_data    = '0;
      uld_rx_req = 1'b0;
      rx_in      = 1'b1;   // serial line idles high
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      open_test("reset values");
      @(posedge clk);
      check_bit("tx_out", 1'b1, tx_out);
      check_bit("tx_empty", 1'b1, tx_empty);
      check_bit("rx_empty", 1'b1, rx_empty);
      check_bit("ld_tx_ack", 1'b0, ld_tx_ack);
      check_bit("uld_rx_ack", 1'b0, uld_rx_ack);
      check_bit("rx_overrun", 1'b0, rx_overrun);
      check_bit("rx_frame_err", 1'b0, rx_frame_err);
      check_byte("rx_data", 8'h00, rx_data);
      close_test();

      open_test("transmit");
      byte_a = 8'($urandom);
      fork
         read_frame(got_a);
         load_byte(byte_a);
      join
      check_byte("tx_out data", byte_a, got_a);
      wait_level("tx_empty", 1'b1, 2 * uart_pkg::CLKS_PER_BIT);
      close_test();

      open_test("transmit back-pressure");
      byte_a = 8'($urandom);
      byte_b = 8'($urandom);
      fork
         begin
            read_frame(got_a);
            read_frame(got_b);
         end
         begin
            load_byte(byte_a);
            tx_data    <= byte_b;
            ld_tx_req  <= 1'b1;
            check_bit("tx_empty", 1'b0, tx_empty);   // first frame still going
            seen_empty = 1'b0;
            waited     = 0;
            @(posedge clk);
            while (ld_tx_ack !== 1'b1 && waited < HANDSHAKE_WAIT)
            begin
               if (tx_empty)
                  seen_empty = 1'b1;
               @(posedge clk);
               waited++;
            end
            if (ld_tx_ack !== 1'b1)
            begin
               error_count++;
               $display("%0t: second load was never acknowledged", $time);
            end
            assert (seen_empty)
            else
            begin
               error_count++;
               $display("%0t: ld_tx_ack rose before tx_empty returned high", $time);
            end
            ld_tx_req <= 1'b0;
            wait_level("ld_tx_ack", 1'b0, HANDSHAKE_WAIT);
         end
      join
      check_byte("tx_out first data", byte_a, got_a);
      check_byte("tx_out second data", byte_b, got_b);
      wait_level("tx_empty", 1'b1, 2 * uart_pkg::CLKS_PER_BIT);
      close_test();

      open_test("receive");
      byte_a = 8'($urandom_range(255, 1));   // nonzero, unlike rx_data after reset
      send_frame(byte_a, 1'b1);
      wait_level("rx_empty", 1'b0, 4);
      unload_byte(got_a, got_err);
      check_byte("rx_data", byte_a, got_a);
      check_bit("rx_frame_err", 1'b0, got_err);
      check_bit("rx_empty", 1'b1, rx_empty);
      close_test();

      open_test("frame error");
      byte_a = 8'($urandom);
      byte_b = 8'($urandom);
      send_frame(byte_a, 1'b0);   // stop bit held low
      unload_byte(got_a, got_err);
      check_byte("rx_data", byte_a, got_a);
      check_bit("rx_frame_err", 1'b1, got_err);
      send_frame(byte_b, 1'b1);
      unload_byte(got_b, got_err);
      check_byte("rx_data", byte_b, got_b);
      check_bit("rx_frame_err", 1'b0, got_err);
      close_test();

      open_test("overrun");
      byte_a = 8'($urandom);
      byte_b = byte_a ^ 8'($urandom_range(255, 1));   // always differs from byte_a
      send_frame(byte_a, 1'b1);
      send_frame(byte_b, 1'b1);
      check_bit("rx_overrun", 1'b1, rx_overrun);
      unload_byte(got_b, got_err);
      check_byte("rx_data", byte_b, got_b);   // newest character wins
      check_bit("rx_overrun", 1'b0, rx_overrun);
      close_test();

      $display("tests run %0d, tests failed %0d, errors %0d", test_count, failed_count,
               error_count);
      if (error_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+sim
src/uart_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/host_port.sv
src/uart_tx.sv
src/uart_top.sv
sim/tb_uart.sv

// ==== Makefile ====
# Verilator build and run for the uart testbench

VERILATOR ?= verilator
TOP       ?= tb_uart
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
